// ==== tb.f ====
+incdir+.
spart_pkg.sv
baud_table.sv
entry_cursor.sv
tx_formatter.sv
driver_ctrl.sv
spart_driver.sv
spart_driver_chk.sv
tb_spart_driver.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the spart_driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_spart_driver -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb_spart_driver.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module tb_spart_driver;

	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_CMDS = 200;
	// A full dump is 30 bytes, each possibly held off by a tbr stretch
	localparam int CMD_WORST_CYCLES = 320;
	localparam int QUIET_CYCLES = 40;
	localparam int TIMEOUT_NS =
		(RESET_CYCLES + NUM_CMDS * CMD_WORST_CYCLES + QUIET_CYCLES) * CLK_PERIOD;

	logic clk;
	logic rst;
	logic [1:0] br_cfg;
	logic iocs;
	logic iorw;
	logic [1:0] ioaddr;
	logic [7:0] databus_in;
	logic [7:0] databus_out;
	logic databus_oe;
	logic rda;
	logic tbr;
	logic [3:0] mem_addr;
	logic [7:0] mem_data;

	integer seed;
	int error_count;
	int write_count;
	int cmd_count;
	int model_cursor;
	int tbr_left;
	// Expected port writes as {ioaddr, byte}
	logic [9:0] expect_q[$];

	spart_driver i_spart_driver (
		.clk(clk),
		.rst(rst),
		.br_cfg(br_cfg),
		.iocs(iocs),
		.iorw(iorw),
		.ioaddr(ioaddr),
		.databus_in(databus_in),
		.databus_out(databus_out),
		.databus_oe(databus_oe),
		.rda(rda),
		.tbr(tbr),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

	// Debug memory contents, fixed rule per address
	assign mem_data = 8'(mem_addr * 7 + 3);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] divisor_for(input logic [1:0] cfg);
		case (cfg)
			2'b00: return 16'h12c0;
			2'b01: return 16'h2580;
			2'b10: return 16'h4b00;
			default: return 16'h9600;
		endcase
	endfunction

	function automatic logic [7:0] ascii_digit(input int val);
		return 8'(val + 48);
	endfunction

	task automatic push_expect(input logic [1:0] addr, input logic [7:0] data);
		expect_q.push_back({addr, data});
	endtask

	task automatic apply_command(input logic [7:0] b);
		int i;
		if (b == `SPART_CHR_DEC) begin
			model_cursor = (model_cursor == 0) ? `SPART_TABLE_LEN - 1 : model_cursor - 1;
			push_expect(`SPART_ADDR_TX, ascii_digit(model_cursor));
		end else if (b == `SPART_CHR_INC) begin
			model_cursor = (model_cursor == `SPART_TABLE_LEN - 1) ? 0 : model_cursor + 1;
			push_expect(`SPART_ADDR_TX, ascii_digit(model_cursor));
		end else if (b == `SPART_CHR_CR) begin
			// Dump runs cursor..9, the cursor itself stays put
			for (i = model_cursor; i < `SPART_TABLE_LEN; i++) begin
				push_expect(`SPART_ADDR_TX, ascii_digit(i));
				push_expect(`SPART_ADDR_TX, ascii_digit((i * 7 + 3) % 256));
				push_expect(`SPART_ADDR_TX, `SPART_CHR_SPACE);
			end
		end
	endtask

	// Mostly cursor moves, some dumps, some junk
	function automatic logic [7:0] pick_command();
		int r;
		logic [7:0] j;
		r = {$random(seed)} % 8;
		if (r < 3)
			return `SPART_CHR_DEC;
		if (r < 6)
			return `SPART_CHR_INC;
		if (r == 6)
			return `SPART_CHR_CR;
		j = 8'($random(seed));
		if (j == `SPART_CHR_DEC || j == `SPART_CHR_INC || j == `SPART_CHR_CR)
			j = j ^ 8'h80;
		return j;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port model and write monitor
	////////////////////////////////////////////////////////////////////////////

	task automatic check_write();
		logic [9:0] exp;
		if (!databus_oe) begin
			error_count++;
			$display("Write cycle at %0t without databus_oe", $time);
		end
		if (ioaddr == `SPART_ADDR_TX && !tbr) begin
			error_count++;
			$display("TX write at %0t while tbr was low", $time);
		end
		if (expect_q.size() == 0) begin
			error_count++;
			$display("Unexpected write at %0t: addr %0d byte %02h", $time, ioaddr, databus_out);
		end else begin
			exp = expect_q.pop_front();
			if ({ioaddr, databus_out} != exp) begin
				error_count++;
				$display("[FAIL] %0t: write addr %0d byte %02h, expected addr %0d byte %02h",
					$time, ioaddr, databus_out, exp[9:8], exp[7:0]);
			end
		end
	endtask

	// Sampled mid-cycle, well clear of both edges
	always @(negedge clk) begin
		if (!rst && databus_oe && !(iocs && !iorw)) begin
			error_count++;
			$display("databus_oe driven at %0t outside a write cycle", $time);
		end
		if (!rst && iocs && !iorw) begin
			write_count++;
			check_write();
		end
	end

	// Random transmit back-pressure in stretches
	always @(posedge clk) begin
		#(DRIVE_DELAY);
		if (tbr_left > 0) begin
			tbr_left--;
		end else begin
			tbr = ({$random(seed)} % 3) != 0;
			tbr_left = {$random(seed)} % 8;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] cmd;
		logic [15:0] div_word;
		int gap;
		seed = 32'h83b0;
		error_count = 0;
		write_count = 0;
		cmd_count = 0;
		model_cursor = 0;
		tbr_left = 0;
		rst = 1'b1;
		rda = 1'b0;
		tbr = 1'b0;
		databus_in = 8'h00;
		br_cfg = 2'($random(seed));
		div_word = divisor_for(br_cfg);
		push_expect(`SPART_ADDR_DIV_LO, div_word[7:0]);
		push_expect(`SPART_ADDR_DIV_HI, div_word[15:8]);

		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		@(negedge clk);

		for (int n = 0; n < NUM_CMDS; n++) begin
			cmd = pick_command();
			gap = {$random(seed)} % 4;
			@(posedge clk);
			#(DRIVE_DELAY);
			rda = 1'b0;
			repeat (gap) begin
				@(posedge clk);
				#(DRIVE_DELAY);
			end
			rda = 1'b1;
			databus_in = cmd;
			// Held until the driver takes it in a read cycle
			@(negedge clk);
			while (!(iocs && iorw))
				@(negedge clk);
			apply_command(cmd);
			cmd_count++;
		end

		@(posedge clk);
		#(DRIVE_DELAY);
		rda = 1'b0;
		databus_in = 8'h00;
		while (expect_q.size() != 0)
			@(negedge clk);
		// Any late write shows up in the monitor as unexpected
		repeat (QUIET_CYCLES) @(negedge clk);

		$display("Commands: %0d, writes checked: %0d, errors: %0d",
			cmd_count, write_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns, the driver stopped making progress", TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spart_driver_chk.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module spart_driver_chk (
	input wire clk,
	input wire rst,
	input wire iocs,
	input wire iorw,
	input wire [1:0] ioaddr,
	input wire databus_oe,
	input wire rda,
	input wire tbr,
	input wire cursor_inc,
	input wire cursor_dec,
	input wire dump_start,
	input wire dump_step
);

	// Reads only with a byte waiting, always from TX
	rd_needs_rda: assert property (@(posedge clk) disable iff (rst)
		(iocs && iorw) |-> (rda && ioaddr == `SPART_ADDR_TX))
		else $error("Read cycle without rda or away from the TX address");

	tx_needs_tbr: assert property (@(posedge clk) disable iff (rst)
		(iocs && !iorw && ioaddr == `SPART_ADDR_TX) |-> tbr)
		else $error("TX write issued while tbr low");

	quiet_in_reset: assert property (@(posedge clk)
		rst |-> !(iocs || databus_oe || cursor_inc || cursor_dec || dump_start || dump_step))
		else $error("Bus or strobe active during reset");

endmodule

bind driver_ctrl spart_driver_chk i_spart_driver_chk (
	.clk(clk),
	.rst(rst),
	.iocs(iocs),
	.iorw(iorw),
	.ioaddr(ioaddr),
	.databus_oe(databus_oe),
	.rda(rda),
	.tbr(tbr),
	.cursor_inc(cursor_inc),
	.cursor_dec(cursor_dec),
	.dump_start(dump_start),
	.dump_step(dump_step)
);

`default_nettype wire

// ==== spart_driver.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module spart_driver (
	input wire clk,
	input wire rst,
	input wire [1:0] br_cfg,
	output logic iocs,
	output logic iorw,
	output logic [1:0] ioaddr,
	input wire [`SPART_DATA_W-1:0] databus_in,
	output logic [`SPART_DATA_W-1:0] databus_out,
	output logic databus_oe,
	input wire rda,
	input wire tbr,
	output logic [`SPART_IDX_W-1:0] mem_addr,
	input wire [`SPART_DATA_W-1:0] mem_data
);

	spart_pkg::chr_sel_e chr_sel;
	logic cursor_inc;
	logic cursor_dec;
	logic dump_start;
	logic dump_step;
	logic dump_last;
	logic [`SPART_IDX_W-1:0] cursor;
	logic [`SPART_DATA_W-1:0] div_lo;
	logic [`SPART_DATA_W-1:0] div_hi;

	driver_ctrl i_driver_ctrl (
		.clk(clk),
		.rst(rst),
		.rda(rda),
		.tbr(tbr),
		.databus_in(databus_in),
		.dump_last(dump_last),
		.iocs(iocs),
		.iorw(iorw),
		.ioaddr(ioaddr),
		.databus_oe(databus_oe),
		.chr_sel(chr_sel),
		.cursor_inc(cursor_inc),
		.cursor_dec(cursor_dec),
		.dump_start(dump_start),
		.dump_step(dump_step)
	);

	baud_table i_baud_table (
		.br_cfg(br_cfg),
		.div_lo(div_lo),
		.div_hi(div_hi)
	);

	// Dump index doubles as the debug read address
	entry_cursor i_entry_cursor (
		.clk(clk),
		.rst(rst),
		.cursor_inc(cursor_inc),
		.cursor_dec(cursor_dec),
		.dump_start(dump_start),
		.dump_step(dump_step),
		.cursor(cursor),
		.index(mem_addr),
		.dump_last(dump_last)
	);

	tx_formatter i_tx_formatter (
		.chr_sel(chr_sel),
		.div_lo(div_lo),
		.div_hi(div_hi),
		.cursor(cursor),
		.index(mem_addr),
		.mem_data(mem_data),
		.databus_out(databus_out)
	);

endmodule

`default_nettype wire

// ==== driver_ctrl.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module driver_ctrl (
	input wire clk,
	input wire rst,
	input wire rda,
	input wire tbr,
	input wire [`SPART_DATA_W-1:0] databus_in,
	input wire dump_last,
	output logic iocs,
	output logic iorw,
	output logic [1:0] ioaddr,
	output logic databus_oe,
	output spart_pkg::chr_sel_e chr_sel,
	output logic cursor_inc,
	output logic cursor_dec,
	output logic dump_start,
	output logic dump_step
);

	spart_pkg::drv_state_e state, next_state;
	logic bus_en;
	logic wr_cycle;
	logic rd_cycle;

	////////////////////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////////////////////

	// bus_en keeps the bus idle until the first edge out of reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= spart_pkg::ST_DIV_LO;
			bus_en <= 1'b0;
		end else begin
			state <= next_state;
			bus_en <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state, strobes and bus cycle select
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		wr_cycle = 1'b0;
		rd_cycle = 1'b0;
		ioaddr = `SPART_ADDR_TX;
		chr_sel = spart_pkg::SEL_SPACE;
		cursor_inc = 1'b0;
		cursor_dec = 1'b0;
		dump_start = 1'b0;
		dump_step = 1'b0;

		case (state)
			spart_pkg::ST_DIV_LO: begin
				ioaddr = `SPART_ADDR_DIV_LO;
				chr_sel = spart_pkg::SEL_DIV_LO;
				if (bus_en) begin
					wr_cycle = 1'b1;
					next_state = spart_pkg::ST_DIV_HI;
				end
			end
			spart_pkg::ST_DIV_HI: begin
				ioaddr = `SPART_ADDR_DIV_HI;
				chr_sel = spart_pkg::SEL_DIV_HI;
				wr_cycle = 1'b1;
				next_state = spart_pkg::ST_RX_WAIT;
			end
			spart_pkg::ST_RX_WAIT: begin
				// Byte is taken off the bus in the read cycle itself
				if (rda) begin
					rd_cycle = 1'b1;
					if (databus_in == `SPART_CHR_DEC) begin
						cursor_dec = 1'b1;
						next_state = spart_pkg::ST_ECHO;
					end else if (databus_in == `SPART_CHR_INC) begin
						cursor_inc = 1'b1;
						next_state = spart_pkg::ST_ECHO;
					end else if (databus_in == `SPART_CHR_CR) begin
						dump_start = 1'b1;
						next_state = spart_pkg::ST_DUMP_IDX;
					end
				end
			end
			spart_pkg::ST_ECHO: begin
				chr_sel = spart_pkg::SEL_CURSOR;
				if (tbr) begin
					wr_cycle = 1'b1;
					next_state = spart_pkg::ST_RX_WAIT;
				end
			end
			spart_pkg::ST_DUMP_IDX: begin
				chr_sel = spart_pkg::SEL_INDEX;
				if (tbr) begin
					wr_cycle = 1'b1;
					next_state = spart_pkg::ST_DUMP_DATA;
				end
			end
			spart_pkg::ST_DUMP_DATA: begin
				chr_sel = spart_pkg::SEL_DATA;
				if (tbr) begin
					wr_cycle = 1'b1;
					next_state = spart_pkg::ST_DUMP_SPACE;
				end
			end
			spart_pkg::ST_DUMP_SPACE: begin
				chr_sel = spart_pkg::SEL_SPACE;
				if (tbr) begin
					wr_cycle = 1'b1;
					if (dump_last) begin
						next_state = spart_pkg::ST_RX_WAIT;
					end else begin
						dump_step = 1'b1;
						next_state = spart_pkg::ST_DUMP_IDX;
					end
				end
			end
			default: next_state = spart_pkg::ST_DIV_LO;
		endcase
	end

	// One port access per cycle, write or read
	assign iocs = wr_cycle | rd_cycle;
	assign iorw = ~wr_cycle;
	assign databus_oe = wr_cycle;

endmodule

`default_nettype wire

// ==== tx_formatter.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module tx_formatter (
	input wire spart_pkg::chr_sel_e chr_sel,
	input wire [`SPART_DATA_W-1:0] div_lo,
	input wire [`SPART_DATA_W-1:0] div_hi,
	input wire [`SPART_IDX_W-1:0] cursor,
	input wire [`SPART_IDX_W-1:0] index,
	input wire [`SPART_DATA_W-1:0] mem_data,
	output logic [`SPART_DATA_W-1:0] databus_out
);

	// Numeric value to its ASCII digit, wraps modulo 256
	function automatic logic [`SPART_DATA_W-1:0] to_digit(
		input logic [`SPART_DATA_W-1:0] val
	);
		return `SPART_CHR_ZERO + val;
	endfunction

	always_comb begin
		case (chr_sel)
			spart_pkg::SEL_DIV_LO: databus_out = div_lo;
			spart_pkg::SEL_DIV_HI: databus_out = div_hi;
			spart_pkg::SEL_CURSOR:
				databus_out = to_digit({{(`SPART_DATA_W-`SPART_IDX_W){1'b0}}, cursor});
			spart_pkg::SEL_INDEX:
				databus_out = to_digit({{(`SPART_DATA_W-`SPART_IDX_W){1'b0}}, index});
			spart_pkg::SEL_DATA: databus_out = to_digit(mem_data);
			default: databus_out = `SPART_CHR_SPACE;
		endcase
	end

endmodule

`default_nettype wire

// ==== entry_cursor.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module entry_cursor (
	input wire clk,
	input wire rst,
	input wire cursor_inc,
	input wire cursor_dec,
	input wire dump_start,
	input wire dump_step,
	output logic [`SPART_IDX_W-1:0] cursor,
	output logic [`SPART_IDX_W-1:0] index,
	output logic dump_last
);

	localparam logic [`SPART_IDX_W-1:0] LAST_IDX = `SPART_IDX_W'(`SPART_TABLE_LEN - 1);

	// Cursor wraps at both ends of the table
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cursor <= '0;
		end else if (cursor_inc) begin
			if (cursor == LAST_IDX)
				cursor <= '0;
			else
				cursor <= cursor + 1'b1;
		end else if (cursor_dec) begin
			if (cursor == '0)
				cursor <= LAST_IDX;
			else
				cursor <= cursor - 1'b1;
		end
	end

	// Dump walk starts at the cursor, leaves the cursor alone
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			index <= '0;
		else if (dump_start)
			index <= cursor;
		else if (dump_step)
			index <= index + 1'b1;
	end

	assign dump_last = (index == LAST_IDX);

endmodule

`default_nettype wire

// ==== baud_table.sv ====
`include "spart_defs.svh"
`default_nettype none
`timescale 1ns/10ps

module baud_table (
	input wire [1:0] br_cfg,
	output logic [`SPART_DATA_W-1:0] div_lo,
	output logic [`SPART_DATA_W-1:0] div_hi
);

	spart_pkg::baud_div_u div;

	// Divisor lookup
	always_comb begin
		case (br_cfg)
			2'b00: div.word = `SPART_DIV_4800;
			2'b01: div.word = `SPART_DIV_9600;
			2'b10: div.word = `SPART_DIV_19200;
			default: div.word = `SPART_DIV_38400;
		endcase
	end

	// Byte view for the two divisor writes
	assign div_lo = div.bytes.lo;
	assign div_hi = div.bytes.hi;

endmodule

`default_nettype wire

// ==== spart_pkg.sv ====
`include "spart_defs.svh"
`default_nettype none

package spart_pkg;

	// Table gives a whole word, the port takes it a byte at a time
	typedef union packed {
		logic [`SPART_DIV_W-1:0] word;
		struct packed {
			logic [`SPART_DATA_W-1:0] hi;
			logic [`SPART_DATA_W-1:0] lo;
		} bytes;
	} baud_div_u;

	typedef enum logic [2:0] {
		ST_DIV_LO,
		ST_DIV_HI,
		ST_RX_WAIT,
		ST_ECHO,
		ST_DUMP_IDX,
		ST_DUMP_DATA,
		ST_DUMP_SPACE
	} drv_state_e;

	// Source of the byte on the outgoing databus
	typedef enum logic [2:0] {
		SEL_DIV_LO,
		SEL_DIV_HI,
		SEL_CURSOR,
		SEL_INDEX,
		SEL_DATA,
		SEL_SPACE
	} chr_sel_e;

endpackage

`default_nettype wire

// ==== spart_defs.svh ====
`default_nettype none

`ifndef SPART_DEFS_SVH
`define SPART_DEFS_SVH

// Port data byte, divisor word and cursor widths
`define SPART_DATA_W 8
`define SPART_DIV_W 16
`define SPART_IDX_W 4

// Entries in the dumped table
`define SPART_TABLE_LEN 10

// Port register addresses
`define SPART_ADDR_TX 2'd0
`define SPART_ADDR_DIV_LO 2'd2
`define SPART_ADDR_DIV_HI 2'd3

// Console characters
`define SPART_CHR_CR 8'h0d
`define SPART_CHR_DEC 8'h31
`define SPART_CHR_INC 8'h32
`define SPART_CHR_ZERO 8'h30
`define SPART_CHR_SPACE 8'h20

// Divisor words per baud rate
`define SPART_DIV_4800 16'h12c0
`define SPART_DIV_9600 16'h2580
`define SPART_DIV_19200 16'h4b00
`define SPART_DIV_38400 16'h9600

`endif

`default_nettype wire
